//--- project.f
+incdir+verilog
verilog/rotator_pkg.sv
verilog/cyclic_bram.sv
verilog/loop_counter.sv
verilog/weight_writer.sv
verilog/weight_reader.sv
verilog/read_fifo.sv
verilog/weight_rotator.sv
verification/tb_weight_rotator.sv

//--- run.sh
#!/bin/sh
# Compile the weight rotator testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  -f project.f \
  --top-module tb_weight_rotator \
  --Mdir obj_dir -o sim_weight_rotator &&
./obj_dir/sim_weight_rotator ||
exit 1

//--- verification/tb_weight_rotator.sv
// Weight rotator testbench
// Sends weight packets, replays them through the DUT and checks every
// output beat against a model of the loop nest and its sideband flags
`include "rotator_cfg.svh"

module tb_weight_rotator;
  timeunit 1ns;
  timeprecision 1ps;
  import rotator_pkg::*;

  localparam int NUM_PKTS = 12;
  localparam logic [31:0] SEED = 32'hb49425cb;

  logic       aclk;
  logic       aresetn;
  logic       i_s_valid;
  logic       o_s_ready;
  weights_t   i_s_data;
  logic       i_s_last;
  logic       o_m_valid;
  logic       i_m_ready;
  out_beat_st o_m_beat;

  config_st    pkt_cfg [NUM_PKTS];
  weights_t    pkt_w [NUM_PKTS][`RAM_DEPTH];
  int          pkt_len [NUM_PKTS];
  int          exp_q [$];
  int          cur_beat = 0;
  int          limit_cycles = 0;
  logic [31:0] lfsr_q;
  logic        in_gap_en;
  logic        out_bp_en;
  logic        hold_ready;

  weight_rotator dut (
    .aclk(aclk), .aresetn(aresetn),
    .i_s_valid(i_s_valid), .o_s_ready(o_s_ready), .i_s_data(i_s_data), .i_s_last(i_s_last),
    .o_m_valid(o_m_valid), .i_m_ready(i_m_ready), .o_m_beat(o_m_beat)
  );

  always #2 aclk = ~aclk;

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  function automatic int draw(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  function automatic void build_packet(int p, int kw2, int cin_1, int cols_1, int blk_1,
                                       int xn_1);
    int nw;
    nw = (2 * kw2 + 1) * (cin_1 + 1);
    pkt_cfg[p].kw2      = KW2_BITS'(kw2);
    pkt_cfg[p].cin_1    = CI_BITS'(cin_1);
    pkt_cfg[p].cols_1   = XW_BITS'(cols_1);
    pkt_cfg[p].blocks_1 = BLK_BITS'(blk_1);
    pkt_cfg[p].xn_1     = XN_BITS'(xn_1);
    pkt_cfg[p].addr_max = ADDR_BITS'(nw - 1);
    for (int i = 0; i < nw; i++) begin
      pkt_w[p][i] = weights_t'(draw(32));
    end
    pkt_len[p] = nw * (cols_1 + 1) * (blk_1 + 1) * (xn_1 + 1);
    limit_cycles = limit_cycles + 20 * (pkt_len[p] + nw + 1);
  endfunction

  // Beat k of the replay, kernel width position changing fastest
  function automatic out_beat_st expected_beat(int p, int k);
    config_st   c;
    out_beat_st b;
    int         kw;
    int         nw;
    int         a;
    int         ci;
    int         col;
    c   = pkt_cfg[p];
    kw  = 2 * int'(c.kw2) + 1;
    nw  = kw * (int'(c.cin_1) + 1);
    a   = k % kw;
    ci  = (k / kw) % (int'(c.cin_1) + 1);
    col = (k / nw) % (int'(c.cols_1) + 1);
    b.data                = pkt_w[p][k % nw];
    b.last                = (k == pkt_len[p] - 1);
    b.user.kw2            = c.kw2;
    b.user.is_w_first_clk = (a == 0) && (ci == 0) && (col == 0);
    b.user.is_cin_last    = (a == kw - 1) && (ci == int'(c.cin_1));
    b.user.is_w_first_kw2 = (int'(c.cols_1) - col) < int'(c.kw2);
    b.user.is_w_last      = (col == int'(c.cols_1));
    return b;
  endfunction

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] want);
    if (got !== want) begin
      abort_run($sformatf("Error at %0d ns: %s got 0x%0h expected 0x%0h",
                          $time, name, got, want));
    end
  endtask

  task automatic drive_beat(weights_t d, logic last);
    while (in_gap_en && draw(2) == 0) begin
      i_s_valid <= 1'b0;
      @(posedge aclk);
    end
    i_s_valid <= 1'b1;
    i_s_data  <= d;
    i_s_last  <= last;
    @(posedge aclk);
    while (!o_s_ready) begin
      @(posedge aclk);
    end
  endtask

  task automatic send_packet(int p);
    logic [31:0] hdr;
    int          am;
    hdr = '0;
    hdr[$bits(config_st)-1:0] = pkt_cfg[p];
    am = int'(pkt_cfg[p].addr_max);
    exp_q.push_back(p);
    drive_beat(weights_t'(hdr), 1'b0);
    for (int i = 0; i <= am; i++) begin
      drive_beat(pkt_w[p][i], i == am);
    end
    i_s_valid <= 1'b0;
    i_s_last  <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge aclk);
    end
  endtask

  task automatic reset_midrun();
    @(posedge aclk);
    aresetn <= 1'b0;
    @(posedge aclk);
    exp_q.delete();
    cur_beat = 0;
    repeat (3) begin
      @(posedge aclk);
      check_value("o_m_valid", 64'(o_m_valid), 64'(0));
      check_value("o_s_ready", 64'(o_s_ready), 64'(0));
    end
    aresetn <= 1'b1;
  endtask

  // Output ready pattern
  always @(posedge aclk) begin
    if (hold_ready) begin
      i_m_ready <= 1'b0;
    end else if (out_bp_en) begin
      i_m_ready <= (draw(2) != 0);
    end else begin
      i_m_ready <= 1'b1;
    end
  end

  always @(posedge aclk) begin : compare
    out_beat_st want;
    if (aresetn && o_m_valid && i_m_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("Output beat arrived while no packet was pending");
      end else begin
        want = expected_beat(exp_q[0], cur_beat);
        check_value("o_m_beat.data", 64'(o_m_beat.data), 64'(want.data));
        check_value("o_m_beat.last", 64'(o_m_beat.last), 64'(want.last));
        check_value("o_m_beat.user", 64'(o_m_beat.user), 64'(want.user));
        cur_beat = cur_beat + 1;
        if (cur_beat == pkt_len[exp_q[0]]) begin
          void'(exp_q.pop_front());
          cur_beat = 0;
        end
      end
    end
  end

  // Starts once all packets are built and reset is released
  initial begin : watchdog
    wait (aresetn === 1'b1);
    repeat (limit_cycles) @(posedge aclk);
    abort_run("Watchdog expired before all output beats were checked");
  end

  initial begin
    aclk       = 1'b0;
    aresetn    = 1'b0;
    i_s_valid  = 1'b0;
    i_s_data   = '0;
    i_s_last   = 1'b0;
    i_m_ready  = 1'b0;
    in_gap_en  = 1'b0;
    out_bp_en  = 1'b0;
    hold_ready = 1'b0;
    lfsr_q     = SEED;
    build_packet(0, 0, 0, 0, 0, 0);
    build_packet(1, 3, 1, 5, 1, 1);
    for (int p = 2; p < 7; p++) begin
      build_packet(p, draw(2), draw(2), draw(3), draw(1), draw(1));
    end
    // Long replays so both banks stay full under a stalled output
    build_packet(7, draw(2), draw(2), 7, draw(1), draw(1));
    build_packet(8, draw(2), draw(2), 7, draw(1), draw(1));
    build_packet(9, draw(2), draw(2), draw(3), draw(1), draw(1));
    build_packet(10, draw(2), draw(2), 15, draw(1), draw(1));
    build_packet(11, draw(2), draw(2), draw(3), draw(1), draw(1));
    repeat (4) @(posedge aclk);
    aresetn <= 1'b1;

    send_packet(0);
    wait_drain();
    send_packet(1);
    wait_drain();

    // Ping-pong overlap
    send_packet(2);
    send_packet(3);
    send_packet(4);
    wait_drain();

    out_bp_en = 1'b1;
    send_packet(5);
    send_packet(6);
    wait_drain();

    // Both banks full with the output stalled
    in_gap_en  = 1'b1;
    hold_ready = 1'b1;
    send_packet(7);
    send_packet(8);
    fork
      send_packet(9);
      begin
        repeat (40) begin
          @(posedge aclk);
          check_value("o_s_ready", 64'(o_s_ready), 64'(0));
        end
        hold_ready = 1'b0;
      end
    join
    wait_drain();
    in_gap_en = 1'b0;

    send_packet(10);
    while (cur_beat < 5) begin
      @(posedge aclk);
    end
    reset_midrun();
    send_packet(11);
    wait_drain();

    // Nothing may follow the last replay
    repeat (20) @(posedge aclk);
    check_value("o_m_valid", 64'(o_m_valid), 64'(0));
    $display("test passed");
    $finish;
  end

endmodule

//--- verilog/weight_rotator.sv
// Weight rotator
// Ping-pong weight buffer: the writer fills one bank while the reader
// replays the other through the loop nest into an output FIFO
module weight_rotator (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    i_s_valid,
  output logic                    o_s_ready,
  input  rotator_pkg::weights_t   i_s_data,
  input  logic                    i_s_last,
  output logic                    o_m_valid,
  input  logic                    i_m_ready,
  output rotator_pkg::out_beat_st o_m_beat
);
  import rotator_pkg::*;

  logic [1:0]           bank_free;
  logic [1:0]           wen;
  logic [1:0]           wclear;
  weights_t             wdata;
  logic                 fill_valid;
  fill_st               fill;
  logic [1:0]           ren;
  logic [1:0]           rrestart;
  weights_t             rdata [2];
  logic [ADDR_BITS-1:0] addr_max [2];
  logic [FREE_BITS-1:0] fifo_free;
  logic                 push;
  out_beat_st           push_beat;

  weight_writer u_writer (
    .aclk(aclk), .aresetn(aresetn),
    .i_s_valid(i_s_valid), .o_s_ready(o_s_ready), .i_s_data(i_s_data), .i_s_last(i_s_last),
    .i_bank_free(bank_free), .o_wen(wen), .o_wdata(wdata), .o_wclear(wclear),
    .o_fill_valid(fill_valid), .o_fill(fill)
  );

  for (genvar b = 0; b < 2; b++) begin : g_bank
    cyclic_bram u_bram (
      .aclk(aclk), .aresetn(aresetn),
      .i_wclear(wclear[b]), .i_wen(wen[b]), .i_wdata(wdata),
      .i_rrestart(rrestart[b]), .i_ren(ren[b]), .i_addr_max(addr_max[b]),
      .o_rdata(rdata[b])
    );
  end

  weight_reader u_reader (
    .aclk(aclk), .aresetn(aresetn),
    .i_fill_valid(fill_valid), .i_fill(fill), .o_bank_free(bank_free),
    .o_addr_max(addr_max), .o_ren(ren), .o_rrestart(rrestart), .i_rdata(rdata),
    .i_fifo_free(fifo_free), .o_push(push), .o_push_beat(push_beat)
  );

  read_fifo u_fifo (
    .aclk(aclk), .aresetn(aresetn),
    .i_push(push), .i_push_beat(push_beat), .o_free(fifo_free),
    .o_m_valid(o_m_valid), .i_m_ready(i_m_ready), .o_m_beat(o_m_beat)
  );

endmodule

//--- verilog/read_fifo.sv
// Output FIFO
// Holds beats that come out of the RAM pipeline while the consumer
// stalls, and reports its free entries to the reader
`include "rotator_cfg.svh"

module read_fifo (
  input  logic                              aclk,
  input  logic                              aresetn,
  input  logic                              i_push,
  input  rotator_pkg::out_beat_st           i_push_beat,
  output logic [rotator_pkg::FREE_BITS-1:0] o_free,
  output logic                              o_m_valid,
  input  logic                              i_m_ready,
  output rotator_pkg::out_beat_st           o_m_beat
);
  import rotator_pkg::*;

  localparam int PTR_BITS = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;

  out_beat_st           mem [`FIFO_DEPTH];
  logic [PTR_BITS-1:0]  wptr;
  logic [PTR_BITS-1:0]  rptr;
  logic [FREE_BITS-1:0] count;
  logic                 pop;

  assign o_m_valid = (count != '0);
  assign pop       = o_m_valid && i_m_ready;
  assign o_m_beat  = mem[rptr];
  assign o_free    = FREE_BITS'(`FIFO_DEPTH) - count;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (i_push) begin
        wptr <= (wptr == PTR_BITS'(`FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
      end
      if (pop) begin
        rptr <= (rptr == PTR_BITS'(`FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
      end
      count <= count + FREE_BITS'(i_push) - FREE_BITS'(pop);
    end
  end

  always_ff @(posedge aclk) begin
    if (i_push) begin
      mem[wptr] <= i_push_beat;
    end
  end

  // The reader's credit check keeps pushes within the free entries
  a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
    i_push |-> count < `FIFO_DEPTH);

endmodule

//--- verilog/weight_reader.sv
// Weight reader
// Tracks which bank is full, replays it through the loop nest and
// tags each beat with the convolution sideband flags
`include "rotator_cfg.svh"

module weight_reader (
  input  logic                              aclk,
  input  logic                              aresetn,
  input  logic                              i_fill_valid,
  input  rotator_pkg::fill_st               i_fill,
  output logic [1:0]                        o_bank_free,
  output logic [rotator_pkg::ADDR_BITS-1:0] o_addr_max [2],
  output logic [1:0]                        o_ren,
  output logic [1:0]                        o_rrestart,
  input  rotator_pkg::weights_t             i_rdata [2],
  input  logic [rotator_pkg::FREE_BITS-1:0] i_fifo_free,
  output logic                              o_push,
  output rotator_pkg::out_beat_st           o_push_beat
);
  import rotator_pkg::*;

  typedef enum logic {
    r_idle,
    r_read
  } rstate_t;

  typedef struct packed {
    logic    valid;
    logic    bank;
    logic    last;
    tuser_st user;
  } meta_st;

  rstate_t              state;
  logic                 r_idx;
  logic [1:0]           full;
  config_st             cfg_q [2];
  config_st             cfg;
  meta_st               meta_q [`RAM_LATENCY];
  meta_st               meta_d;
  meta_st               meta_out;
  logic [FREE_BITS-1:0] in_flight;
  logic                 start;
  logic                 rd_issue;
  logic [XW_BITS-1:0]   c_cols;
  logic                 f_kw, l_kw, w_kw;
  logic                 f_cin, l_cin, w_cin;
  logic                 f_cols, l_cols, w_cols;
  logic                 w_blk, w_xn;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      full <= '0;
    end else begin
      if (i_fill_valid) begin
        full[i_fill.bank] <= 1'b1;
      end
      if (w_xn) begin
        full[r_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_fill_valid) begin
      cfg_q[i_fill.bank] <= i_fill.cfg;
    end
  end

  assign o_bank_free   = ~full;
  assign o_addr_max[0] = cfg_q[0].addr_max;
  assign o_addr_max[1] = cfg_q[1].addr_max;
  assign cfg           = cfg_q[r_idx];

  // Credit check against the FIFO, counting reads still in the RAM
  assign start    = (state == r_idle) && full[r_idx];
  assign rd_issue = (state == r_read) && (i_fifo_free > in_flight);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= r_idle;
      r_idx <= 1'b0;
    end else if (start) begin
      state <= r_read;
    end else if (w_xn) begin
      state <= r_idle;
      r_idx <= ~r_idx;
    end
  end

  always_comb begin
    o_ren             = '0;
    o_rrestart        = '0;
    o_ren[r_idx]      = rd_issue;
    o_rrestart[r_idx] = start;
  end

  // Loop nest, fastest first
  loop_counter #(.W(KW_BITS)) u_kw (
    .aclk(aclk), .aresetn(aresetn), .i_clear(start), .i_en(rd_issue),
    .i_max(KW_BITS'({cfg.kw2, 1'b0})),
    .o_count(), .o_first(f_kw), .o_last(l_kw), .o_wrap(w_kw)
  );
  loop_counter #(.W(CI_BITS)) u_cin (
    .aclk(aclk), .aresetn(aresetn), .i_clear(start), .i_en(w_kw), .i_max(cfg.cin_1),
    .o_count(), .o_first(f_cin), .o_last(l_cin), .o_wrap(w_cin)
  );
  loop_counter #(.W(XW_BITS)) u_cols (
    .aclk(aclk), .aresetn(aresetn), .i_clear(start), .i_en(w_cin), .i_max(cfg.cols_1),
    .o_count(c_cols), .o_first(f_cols), .o_last(l_cols), .o_wrap(w_cols)
  );
  loop_counter #(.W(BLK_BITS)) u_blocks (
    .aclk(aclk), .aresetn(aresetn), .i_clear(start), .i_en(w_cols), .i_max(cfg.blocks_1),
    .o_count(), .o_first(), .o_last(), .o_wrap(w_blk)
  );
  loop_counter #(.W(XN_BITS)) u_xn (
    .aclk(aclk), .aresetn(aresetn), .i_clear(start), .i_en(w_blk), .i_max(cfg.xn_1),
    .o_count(), .o_first(), .o_last(), .o_wrap(w_xn)
  );

  assign meta_d.valid               = rd_issue;
  assign meta_d.bank                = r_idx;
  assign meta_d.last                = w_xn;
  assign meta_d.user.kw2            = cfg.kw2;
  assign meta_d.user.is_w_first_clk = f_kw && f_cin && f_cols;
  assign meta_d.user.is_cin_last    = l_kw && l_cin;
  assign meta_d.user.is_w_first_kw2 = (cfg.cols_1 - c_cols) < XW_BITS'(cfg.kw2);
  assign meta_d.user.is_w_last      = l_cols;

  // Meta follows the read through the RAM pipeline
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      meta_q <= '{default: '0};
    end else begin
      meta_q[0] <= meta_d;
      for (int i = 1; i < `RAM_LATENCY; i++) begin
        meta_q[i] <= meta_q[i-1];
      end
    end
  end

  always_comb begin
    in_flight = '0;
    for (int i = 0; i < `RAM_LATENCY; i++) begin
      in_flight = in_flight + FREE_BITS'(meta_q[i].valid);
    end
  end

  assign meta_out         = meta_q[`RAM_LATENCY-1];
  assign o_push           = meta_out.valid;
  assign o_push_beat.data = i_rdata[meta_out.bank];
  assign o_push_beat.last = meta_out.last;
  assign o_push_beat.user = meta_out.user;

endmodule

//--- verilog/weight_writer.sv
// Weight writer
// Takes one packet per free bank, latches the header and writes the
// weight beats, then hands the bank to the reader
module weight_writer (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  i_s_valid,
  output logic                  o_s_ready,
  input  rotator_pkg::weights_t i_s_data,
  input  logic                  i_s_last,
  input  logic [1:0]            i_bank_free,
  output logic [1:0]            o_wen,
  output rotator_pkg::weights_t o_wdata,
  output logic [1:0]            o_wclear,
  output logic                  o_fill_valid,
  output rotator_pkg::fill_st   o_fill
);
  import rotator_pkg::*;

  typedef enum logic [1:0] {
    w_idle,
    w_header,
    w_write
  } wstate_t;

  wstate_t                     state;
  logic                        w_idx;
  config_st                    cfg_q;
  logic [ADDR_BITS:0]          beat_cnt;
  logic                        s_hs;
  logic                        last_hs;
  logic [$bits(weights_t)-1:0] s_bits;

  assign o_s_ready = (state == w_header) || (state == w_write);
  assign s_hs      = i_s_valid && o_s_ready;
  assign last_hs   = s_hs && (state == w_write) && i_s_last;

  // Header fields sit in the low bits across the words
  assign s_bits    = i_s_data;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= w_idle;
      w_idx <= 1'b0;
    end else begin
      case (state)
        w_idle: begin
          if (i_bank_free[w_idx]) begin
            state <= w_header;
          end
        end
        w_header: begin
          if (s_hs) begin
            state <= w_write;
          end
        end
        w_write: begin
          if (last_hs) begin
            state <= w_idle;
            w_idx <= ~w_idx;
          end
        end
        default: state <= w_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state == w_header) begin
      beat_cnt <= '0;
      if (s_hs) begin
        cfg_q <= config_st'(s_bits[$bits(config_st)-1:0]);
      end
    end else if (s_hs) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  always_comb begin
    o_wen             = '0;
    o_wclear          = '0;
    o_wen[w_idx]      = (state == w_write) && s_hs;
    o_wclear[w_idx]   = (state == w_header);
  end

  assign o_wdata      = i_s_data;
  assign o_fill_valid = last_hs;
  assign o_fill.bank  = w_idx;
  assign o_fill.cfg   = cfg_q;

  // Source must send exactly addr_max + 1 weight beats
  a_packet_len: assert property (@(posedge aclk) disable iff (!aresetn)
    last_hs |-> beat_cnt == {1'b0, cfg_q.addr_max});

endmodule

//--- verilog/loop_counter.sv
// Loop counter
// Wrapping up-counter with first and last flags, chained through o_wrap
// to build a loop nest
module loop_counter #(
  parameter int W = 4
) (
  input  logic         aclk,
  input  logic         aresetn,
  input  logic         i_clear,
  input  logic         i_en,
  input  logic [W-1:0] i_max,
  output logic [W-1:0] o_count,
  output logic         o_first,
  output logic         o_last,
  output logic         o_wrap
);

  always_ff @(posedge aclk) begin
    if (!aresetn || i_clear) begin
      o_count <= '0;
    end else if (i_en) begin
      o_count <= o_last ? '0 : o_count + 1'b1;
    end
  end

  assign o_first = (o_count == '0);
  assign o_last  = (o_count == i_max);

  // Enables the next, slower loop
  assign o_wrap  = i_en && o_last;

endmodule

//--- verilog/cyclic_bram.sv
// Weight bank
// Linear writes of one rotation, reads that wrap after the last beat,
// read data returned through a fixed register pipeline
`include "rotator_cfg.svh"

module cyclic_bram (
  input  logic                              aclk,
  input  logic                              aresetn,
  input  logic                              i_wclear,
  input  logic                              i_wen,
  input  rotator_pkg::weights_t             i_wdata,
  input  logic                              i_rrestart,
  input  logic                              i_ren,
  input  logic [rotator_pkg::ADDR_BITS-1:0] i_addr_max,
  output rotator_pkg::weights_t             o_rdata
);
  import rotator_pkg::*;

  weights_t             mem [`RAM_DEPTH];
  weights_t             rd_pipe [`RAM_LATENCY];
  logic [ADDR_BITS:0]   wptr;
  logic [ADDR_BITS-1:0] rptr;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wptr <= '0;
    end else if (i_wclear) begin
      wptr <= '0;
    end else if (i_wen) begin
      wptr <= wptr + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_wen) begin
      mem[wptr[ADDR_BITS-1:0]] <= i_wdata;
    end
  end

  // Wraps at the end of one rotation
  always_ff @(posedge aclk) begin
    if (!aresetn || i_rrestart) begin
      rptr <= '0;
    end else if (i_ren) begin
      rptr <= (rptr == i_addr_max) ? '0 : rptr + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_ren) begin
      rd_pipe[0] <= mem[rptr];
    end
    for (int i = 1; i < `RAM_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign o_rdata = rd_pipe[`RAM_LATENCY-1];

  // Packet length was checked against the depth upstream
  a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
    i_wen |-> wptr < `RAM_DEPTH);

endmodule

//--- verilog/rotator_pkg.sv
// Weight rotator types
// Header, sideband and beat layouts shared by the rotator blocks
`include "rotator_cfg.svh"

package rotator_pkg;

  localparam int ADDR_BITS = $clog2(`RAM_DEPTH);
  localparam int KW2_BITS  = $clog2((`KW_MAX + 1) / 2);
  localparam int KW_BITS   = $clog2(`KW_MAX);
  localparam int CI_BITS   = $clog2(`CI_MAX);
  localparam int XW_BITS   = $clog2(`XW_MAX);
  localparam int BLK_BITS  = $clog2(`BLK_MAX);
  localparam int XN_BITS   = $clog2(`XN_MAX);
  localparam int FREE_BITS = $clog2(`FIFO_DEPTH + 1);

  typedef logic [`COLS-1:0][`WORD_BITS-1:0] weights_t;

  // Sits in the low bits of the header beat
  typedef struct packed {
    logic [ADDR_BITS-1:0] addr_max;
    logic [XN_BITS-1:0]   xn_1;
    logic [BLK_BITS-1:0]  blocks_1;
    logic [XW_BITS-1:0]   cols_1;
    logic [CI_BITS-1:0]   cin_1;
    logic [KW2_BITS-1:0]  kw2;
  } config_st;

  typedef struct packed {
    logic [KW2_BITS-1:0] kw2;
    logic                is_w_first_clk;
    logic                is_cin_last;
    logic                is_w_first_kw2;
    logic                is_w_last;
  } tuser_st;

  typedef struct packed {
    weights_t data;
    logic     last;
    tuser_st  user;
  } out_beat_st;

  typedef struct packed {
    logic     bank;
    config_st cfg;
  } fill_st;

endpackage

//--- verilog/rotator_cfg.svh
// Weight rotator configuration
// Sizes of the weight path, loop limits and the RAM read timing
`ifndef ROTATOR_CFG_SVH
`define ROTATOR_CFG_SVH

// One weight beat
`define WORD_BITS 8
`define COLS 4

// Beats per bank
`define RAM_DEPTH 64

// Loop limits
`define KW_MAX 7
`define CI_MAX 8
`define XW_MAX 16
`define BLK_MAX 4
`define XN_MAX 4

`define RAM_LATENCY 2
`define FIFO_DEPTH 4

`endif
